//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module rv_core_tb -f rv_core.f

out=$(./obj_dir/Vrv_core_tb +verilator+error+limit+100 || true)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- rv_core.f
verilog/rv_core_pkg.sv
verilog/control.sv
verilog/imm_gen.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/rv_core.sv
test/rv_core_assertions.sv
test/rv_core_tb.sv

//--- test/rv_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_assertions import rv_core_pkg::*; (
        input  wire logic  clk,
        input  wire logic  rst_n,
        input  wire logic  instr_valid,
        input  wire wb_t   wb
);

        int failures = 0;

        // two registered stages and no stalls
        latency_check: assert property (@(posedge clk) disable iff (!rst_n)
                wb.valid == $past(instr_valid, 2))
        else begin
                failures++;
                $error("wb.valid does not follow instr_valid by two cycles");
        end

        idle_flags_check: assert property (@(posedge clk) disable iff (!rst_n)
                !wb.valid |-> !(wb.reg_write || wb.mem_write || wb.branch_taken))
        else begin
                failures++;
                $error("wb flags set while wb.valid is low");
        end

        write_exclusive_check: assert property (@(posedge clk) disable iff (!rst_n)
                !(wb.reg_write && wb.mem_write))
        else begin
                failures++;
                $error("wb.reg_write and wb.mem_write set together");
        end

endmodule

bind rv_core rv_core_assertions u_assertions (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .wb          (wb)
);

`default_nettype wire

//--- test/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

        typedef struct packed {
                logic [31:0] word;
                logic [4:0]  rd;
                logic        reg_write;
                logic        mem_write;
                logic        branch_taken;
                logic [31:0] data;
                logic        chained;     // no idle cycle before this row
        } row_t;

        logic         clk;
        logic         rst_n;
        logic         instr_valid;
        instruction_t instruction;
        wb_t          wb;

        row_t rows[$];
        int   seed = 32'hb56e959a;
        int   check_idx = 0;
        int   pass_count = 0;
        int   error_count = 0;
        int   row_errors;
        int   cycle_count = 0;
        int   cycle_limit = 20;
        int   gap;

        rv_core dut (
                .clk         (clk),
                .rst_n       (rst_n),
                .instr_valid (instr_valid),
                .instruction (instruction),
                .wb          (wb)
        );

        function automatic logic [31:0] r_type_word(input int f7, input int rs2, input int rs1,
                                                    input int f3, input int rd);
                r_type_word = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
        endfunction

        function automatic logic [31:0] i_type_word(input logic [6:0] op, input int imm,
                                                    input int rs1, input int f3, input int rd);
                i_type_word = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
        endfunction

        // sw only
        function automatic logic [31:0] s_type_word(input int imm, input int rs2, input int rs1);
                s_type_word = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
        endfunction

        function automatic logic [31:0] b_type_word(input int imm, input int rs2, input int rs1,
                                                    input int f3);
                b_type_word = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0],
                               imm[4:1], imm[11], op_branch};
        endfunction

        function automatic logic [31:0] u_type_word(input logic [6:0] op, input int imm,
                                                    input int rd);
                u_type_word = {imm[19:0], rd[4:0], op};
        endfunction

        task automatic add_row(input logic [31:0] word, input int rd, input int rw,
                               input int mw, input int bt, input logic [31:0] data);
                row_t r;
                r.word = word;
                r.rd = rd[4:0];
                r.reg_write = (rw != 0);
                r.mem_write = (mw != 0);
                r.branch_taken = (bt != 0);
                r.data = data;
                r.chained = 1'b0;
                rows.push_back(r);
        endtask

        // issued right after the previous row, reads its result on the next cycle
        task automatic add_chained_row(input logic [31:0] word, input int rd, input int rw,
                                       input int mw, input int bt, input logic [31:0] data);
                add_row(word, rd, rw, mw, bt, data);
                rows[rows.size() - 1].chained = 1'b1;
        endtask

        // x6 = -5 and x7 = 3 for the signed cases
        task automatic build_table();
                add_row(u_type_word(op_lui, 32'h12345, 1), 1, 1, 0, 0, 32'h12345000);
                add_row(i_type_word(op_imm, 100, 0, 0, 2), 2, 1, 0, 0, 32'h64);
                add_row(i_type_word(op_imm, -7, 2, 0, 3), 3, 1, 0, 0, 32'h5d);
                add_row(i_type_word(op_imm, 32'h678, 1, 0, 4), 4, 1, 0, 0, 32'h12345678);
                add_chained_row(r_type_word(0, 2, 4, 0, 5), 5, 1, 0, 0, 32'h123456dc);
                add_row(i_type_word(op_imm, -5, 0, 0, 6), 6, 1, 0, 0, 32'hfffffffb);
                add_row(i_type_word(op_imm, 3, 0, 0, 7), 7, 1, 0, 0, 32'h3);
                add_row(r_type_word(32, 6, 7, 0, 8), 8, 1, 0, 0, 32'h8);
                add_row(r_type_word(0, 7, 6, 2, 10), 10, 1, 0, 0, 32'h1);
                add_row(r_type_word(0, 7, 6, 3, 11), 11, 1, 0, 0, 32'h0);
                add_row(i_type_word(op_imm, -4, 6, 2, 14), 14, 1, 0, 0, 32'h1);
                add_row(i_type_word(op_imm, -1, 7, 3, 15), 15, 1, 0, 0, 32'h1);
                add_row(r_type_word(0, 1, 4, 4, 16), 16, 1, 0, 0, 32'h678);
                add_row(r_type_word(0, 6, 7, 6, 17), 17, 1, 0, 0, 32'hfffffffb);
                add_row(r_type_word(0, 7, 6, 7, 18), 18, 1, 0, 0, 32'h3);
                add_row(i_type_word(op_imm, -1, 7, 4, 19), 19, 1, 0, 0, 32'hfffffffc);
                add_row(i_type_word(op_imm, 32'h7f0, 7, 6, 20), 20, 1, 0, 0, 32'h7f3);
                add_row(i_type_word(op_imm, 32'hff, 4, 7, 21), 21, 1, 0, 0, 32'h78);
                add_row(r_type_word(0, 7, 7, 1, 22), 22, 1, 0, 0, 32'h18);
                add_row(i_type_word(op_imm, 4, 6, 1, 23), 23, 1, 0, 0, 32'hffffffb0);
                add_row(r_type_word(0, 7, 6, 5, 24), 24, 1, 0, 0, 32'h1fffffff);
                add_row(r_type_word(32, 7, 6, 5, 25), 25, 1, 0, 0, 32'hffffffff);
                add_row(i_type_word(op_imm, 1, 6, 5, 26), 26, 1, 0, 0, 32'h7ffffffd);
                add_row(i_type_word(op_imm, 32'h401, 6, 5, 27), 27, 1, 0, 0, 32'hfffffffd);
                add_row(s_type_word(8, 4, 2), 0, 0, 1, 0, 32'h6c);   // store reports address
                add_row(i_type_word(op_load, 8, 2, 2, 28), 28, 1, 0, 0, 32'h12345678);
                add_row(i_type_word(op_imm, 3, 0, 0, 30), 30, 1, 0, 0, 32'h3);
                add_row(b_type_word(16, 30, 7, 0), 0, 0, 0, 1, 32'h0);
                add_row(b_type_word(16, 6, 7, 0), 0, 0, 0, 0, 32'h0);
                add_row(b_type_word(-8, 6, 7, 1), 0, 0, 0, 1, 32'h0);
                add_row(b_type_word(-8, 30, 7, 1), 0, 0, 0, 0, 32'h0);
                add_row(b_type_word(32, 7, 6, 4), 0, 0, 0, 1, 32'h0);
                add_row(b_type_word(32, 6, 7, 4), 0, 0, 0, 0, 32'h0);
                add_row(b_type_word(12, 6, 7, 5), 0, 0, 0, 1, 32'h0);
                add_row(b_type_word(12, 7, 6, 5), 0, 0, 0, 0, 32'h0);
                add_row(b_type_word(20, 6, 7, 6), 0, 0, 0, 1, 32'h0);
                add_row(b_type_word(20, 7, 6, 6), 0, 0, 0, 0, 32'h0);
                add_row(b_type_word(-16, 7, 6, 7), 0, 0, 0, 1, 32'h0);
                add_row(b_type_word(-16, 6, 7, 7), 0, 0, 0, 0, 32'h0);
                add_row(i_type_word(op_imm, 32'h20, 7, 0, 0), 0, 1, 0, 0, 32'h23);
                add_row(r_type_word(0, 7, 0, 0, 31), 31, 1, 0, 0, 32'h3);  // x0 reads back 0
                add_row(r_type_word(1, 7, 6, 0, 5), 0, 0, 0, 0, 32'h0);    // mul
                add_row(u_type_word(7'b1101111, 32'h00400, 1), 0, 0, 0, 0, 32'h0);  // jal
                add_row(i_type_word(op_imm, 0, 1, 0, 31), 31, 1, 0, 0, 32'h12345000);
                add_row(i_type_word(op_imm, 0, 5, 0, 31), 31, 1, 0, 0, 32'h123456dc);
        endtask

        task automatic compare_field(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
                if (got !== exp) begin
                        $display("** Error row %0d: %s is 0x%h, expected 0x%h",
                                 check_idx, name, got, exp);
                        row_errors++;
                        error_count++;
                end
        endtask

        task automatic check_record(input row_t exp);
                row_errors = 0;
                compare_field("wb.rd", 32'(wb.rd), 32'(exp.rd));
                compare_field("wb.reg_write", 32'(wb.reg_write), 32'(exp.reg_write));
                compare_field("wb.mem_write", 32'(wb.mem_write), 32'(exp.mem_write));
                compare_field("wb.branch_taken", 32'(wb.branch_taken), 32'(exp.branch_taken));
                compare_field("wb.data", wb.data, exp.data);
                if (row_errors == 0) begin
                        pass_count++;
                        $display("row %0d ok: rd %0d data 0x%h", check_idx, wb.rd, wb.data);
                end else begin
                        $display("row %0d failed with %0d mismatches", check_idx, row_errors);
                end
        endtask

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // wb only moves on posedge
        always @(negedge clk) begin
                if (rst_n && wb.valid) begin
                        if (check_idx < rows.size()) begin
                                check_record(rows[check_idx]);
                        end else begin
                                $display("unexpected write-back record after the last row, data 0x%h",
                                         wb.data);
                                error_count++;
                        end
                        check_idx++;
                end
        end

        always @(posedge clk) begin
                cycle_count++;
                if (cycle_count > cycle_limit) begin
                        $display("timeout after %0d cycles, only %0d of %0d write-back records seen",
                                 cycle_count, check_idx, rows.size());
                        $display("TEST FAIL");
                        $finish;
                end
        end

        initial begin
                rst_n = 1'b0;
                instr_valid = 1'b0;
                instruction = '0;
                build_table();
                cycle_limit = 4 * rows.size() + 20;
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                foreach (rows[i]) begin
                        instr_valid = 1'b1;
                        instruction = rows[i].word;
                        @(negedge clk);
                        instr_valid = 1'b0;
                        instruction = '0;
                        gap = $unsigned($random(seed)) % 3;   // 0 to 2 idle cycles
                        if (i + 1 < rows.size() && rows[i + 1].chained)
                                gap = 0;
                        repeat (gap) @(negedge clk);
                end
                wait (check_idx >= rows.size());
                repeat (3) @(negedge clk);   // room for a stray record
                $display("%0d rows passed, %0d errors, %0d assertion failures",
                         pass_count, error_count, dut.u_assertions.failures);
                if (error_count == 0 && dut.u_assertions.failures == 0 &&
                    pass_count == rows.size())
                        $display("TEST PASS");
                else
                        $display("TEST FAIL");
                $finish;
        end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import rv_core_pkg::*; (
        input  wire alu_op_t          alu_op,
        input  wire logic [2:0]       funct3,
        input  wire logic [xlen-1:0]  a,
        input  wire logic [xlen-1:0]  b,
        output logic [xlen-1:0]       result,
        output logic                  cond
);

        logic [xlen:0] diff;     // msb is the borrow
        logic [4:0]    shamt;
        logic          eq;
        logic          lt;
        logic          ltu;

        assign diff = {1'b0, a} - {1'b0, b};
        assign shamt = b[4:0];

        // compares all come from the one subtraction
        assign eq = (diff[xlen-1:0] == '0);
        assign ltu = diff[xlen];
        assign lt = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : diff[xlen-1];

        always_comb begin
                case (alu_op)
                ALU_ADD:                result = a + b;
                ALU_SUB:                result = diff[xlen-1:0];
                ALU_AND:                result = a & b;
                ALU_OR:                 result = a | b;
                ALU_XOR:                result = a ^ b;
                ALU_SHIFT_LEFT:         result = a << shamt;
                ALU_SHIFT_RIGHT:        result = a >> shamt;
                ALU_SHIFT_RIGHT_AR:     result = $signed(a) >>> shamt;
                ALU_LESS_THAN_SIGNED:   result = {{(xlen-1){1'b0}}, lt};
                ALU_LESS_THAN_UNSIGNED: result = {{(xlen-1){1'b0}}, ltu};
                ALU_PASS_B:             result = b;   // lui
                default:                result = '0;
                endcase
        end

        always_comb begin
                case (funct3)
                3'b000:  cond = eq;     // beq
                3'b001:  cond = !eq;
                3'b100:  cond = lt;
                3'b101:  cond = !lt;
                3'b110:  cond = ltu;
                3'b111:  cond = !ltu;
                default: cond = 1'b0;
                endcase
        end

endmodule

`default_nettype wire

//--- verilog/control.sv
`timescale 1ns/100ps
`default_nettype none

module control import rv_core_pkg::*; (
        input  wire instruction_t instruction,
        output control_t          control
);

        control_t   ctrl;
        logic       supported;
        logic [6:0] funct7;
        logic [2:0] funct3;

        assign funct7 = instruction.r_fmt.funct7;
        assign funct3 = instruction.r_fmt.funct3;

        // funct3 map shared by OP and OP-IMM
        function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt,
                                             input logic sub_ok);
                case (f3)
                3'b000: arith_op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
                3'b001: arith_op = ALU_SHIFT_LEFT;
                3'b010: arith_op = ALU_LESS_THAN_SIGNED;
                3'b011: arith_op = ALU_LESS_THAN_UNSIGNED;
                3'b100: arith_op = ALU_XOR;
                3'b101: arith_op = alt ? ALU_SHIFT_RIGHT_AR : ALU_SHIFT_RIGHT;
                3'b110: arith_op = ALU_OR;
                default: arith_op = ALU_AND;
                endcase
        endfunction

        always_comb begin
                ctrl = '0;
                supported = 1'b0;
                ctrl.write_back_id = instruction.r_fmt.rd;

                case (instruction.r_fmt.opcode)
                op_lui: begin
                        ctrl.encoding = U_TYPE;
                        ctrl.alu_op = ALU_PASS_B;
                        ctrl.alu_src = 1'b1;
                        ctrl.reg_write = 1'b1;
                        supported = 1'b1;
                end
                op_branch: begin
                        ctrl.encoding = B_TYPE;
                        ctrl.alu_op = ALU_SUB;     // compare against rs2
                        ctrl.is_branch = 1'b1;
                        supported = (funct3[2:1] != 2'b01);
                end
                op_load: begin
                        ctrl.encoding = I_TYPE;
                        ctrl.alu_op = ALU_ADD;
                        ctrl.alu_src = 1'b1;
                        ctrl.mem_read = 1'b1;
                        ctrl.reg_write = 1'b1;
                        supported = (funct3 == 3'b010);  // lw only
                end
                op_store: begin
                        ctrl.encoding = S_TYPE;
                        ctrl.alu_op = ALU_ADD;
                        ctrl.alu_src = 1'b1;
                        ctrl.mem_write = 1'b1;
                        supported = (funct3 == 3'b010);  // sw only
                end
                op_imm: begin
                        ctrl.encoding = I_TYPE;
                        ctrl.alu_op = arith_op(funct3, funct7[5], 1'b0);
                        ctrl.alu_src = 1'b1;
                        ctrl.reg_write = 1'b1;
                        if (funct3 == 3'b001)
                                supported = (funct7 == 7'b0000000);
                        else if (funct3 == 3'b101)
                                supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                        else
                                supported = 1'b1;
                end
                op_reg: begin
                        ctrl.encoding = R_TYPE;
                        ctrl.alu_op = arith_op(funct3, funct7[5], 1'b1);
                        ctrl.reg_write = 1'b1;
                        // funct7 0000001 is the M extension
                        supported = (funct7 == 7'b0000000) ||
                                    (funct7 == 7'b0100000 &&
                                     (funct3 == 3'b000 || funct3 == 3'b101));
                end
                default: begin
                        supported = 1'b0;
                end
                endcase
        end

        assign control = supported ? ctrl : '0;   // nothing leaks from unknown words

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage import rv_core_pkg::*; (
        input  wire logic          clk,
        input  wire logic          rst_n,
        input  wire logic          instr_valid,
        input  wire instruction_t  instruction,
        output decoded_t           decoded
);

        control_t        ctrl;
        logic [xlen-1:0] imm;

        control u_control (
                .instruction (instruction),
                .control     (ctrl)
        );

        imm_gen u_imm_gen (
                .instruction (instruction),
                .encoding    (ctrl.encoding),
                .imm         (imm)
        );

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        decoded <= '0;
                end else begin
                        decoded.valid <= instr_valid;
                        decoded.ctrl <= ctrl;
                        decoded.rs1 <= instruction.r_fmt.rs1;
                        decoded.rs2 <= instruction.r_fmt.rs2;
                        decoded.funct3 <= instruction.r_fmt.funct3;
                        decoded.imm <= imm;
                end
        end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage import rv_core_pkg::*; (
        input  wire logic      clk,
        input  wire logic      rst_n,
        input  wire decoded_t  decoded,
        output wb_t            wb
);

        logic [xlen-1:0]        rs1_data;
        logic [xlen-1:0]        rs2_data;
        logic [xlen-1:0]        op_b;
        logic [xlen-1:0]        result;
        logic                   cond;
        logic [xlen-1:0]        wr_data;
        logic                   reg_we;
        logic [dmem_addr_w-1:0] dmem_idx;
        logic [xlen-1:0]        dmem [0:dmem_words-1];
        wb_t                    wb_next;

        // branches never set alu_src, so they compare against rs2
        assign op_b = decoded.ctrl.alu_src ? decoded.imm : rs2_data;
        assign reg_we = decoded.valid & decoded.ctrl.reg_write;

        reg_file u_reg_file (
                .clk      (clk),
                .rst_n    (rst_n),
                .rs1      (decoded.rs1),
                .rs2      (decoded.rs2),
                .rd_data1 (rs1_data),
                .rd_data2 (rs2_data),
                .we       (reg_we),
                .rd       (decoded.ctrl.write_back_id),
                .wd       (wr_data)
        );

        alu u_alu (
                .alu_op (decoded.ctrl.alu_op),
                .funct3 (decoded.funct3),
                .a      (rs1_data),
                .b      (op_b),
                .result (result),
                .cond   (cond)
        );

        assign dmem_idx = result[dmem_addr_w+1:2];   // word address
        assign wr_data = decoded.ctrl.mem_read ? dmem[dmem_idx] : result;

        always_comb begin
                wb_next = '0;
                wb_next.valid = decoded.valid;
                if (decoded.valid) begin
                        wb_next.mem_write = decoded.ctrl.mem_write;
                        wb_next.branch_taken = decoded.ctrl.is_branch & cond;
                        if (decoded.ctrl.reg_write) begin
                                wb_next.reg_write = 1'b1;
                                wb_next.rd = decoded.ctrl.write_back_id;
                                wb_next.data = wr_data;
                        end else if (decoded.ctrl.mem_write) begin
                                wb_next.data = result;   // store address
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < dmem_words; i++)
                                dmem[i] <= '0;
                end else if (decoded.valid && decoded.ctrl.mem_write) begin
                        dmem[dmem_idx] <= rs2_data;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        wb <= '0;
                else
                        wb <= wb_next;
        end

endmodule

`default_nettype wire

//--- verilog/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen import rv_core_pkg::*; (
        input  wire instruction_t  instruction,
        input  wire encoding_t     encoding,
        output logic [xlen-1:0]    imm
);

        always_comb begin
                case (encoding)
                I_TYPE: begin
                        imm = {{20{instruction.i_fmt.imm_11_0[11]}},
                               instruction.i_fmt.imm_11_0};
                end
                S_TYPE: begin
                        imm = {{20{instruction.s_fmt.imm_11_5[6]}},
                               instruction.s_fmt.imm_11_5,
                               instruction.s_fmt.imm_4_0};
                end
                B_TYPE: begin
                        // bit 0 always zero
                        imm = {{20{instruction.b_fmt.imm_12}},
                               instruction.b_fmt.imm_11,
                               instruction.b_fmt.imm_10_5,
                               instruction.b_fmt.imm_4_1,
                               1'b0};
                end
                U_TYPE: begin
                        imm = {instruction.u_fmt.imm_31_12, 12'b0};
                end
                default: begin
                        imm = '0;     // R type has no immediate
                end
                endcase
        end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
        input  wire logic                  clk,
        input  wire logic                  rst_n,
        input  wire logic [reg_addr_w-1:0] rs1,
        input  wire logic [reg_addr_w-1:0] rs2,
        output logic [xlen-1:0]            rd_data1,
        output logic [xlen-1:0]            rd_data2,
        input  wire logic                  we,
        input  wire logic [reg_addr_w-1:0] rd,
        input  wire logic [xlen-1:0]       wd
);

        // x0 has no storage
        logic [xlen-1:0] regs [1:2**reg_addr_w-1];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 1; i < 2**reg_addr_w; i++)
                                regs[i] <= '0;
                end else if (we && rd != '0) begin
                        regs[rd] <= wd;
                end
        end

        assign rd_data1 = (rs1 == '0) ? '0 : regs[rs1];
        assign rd_data2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
        input  wire logic          clk,
        input  wire logic          rst_n,
        input  wire logic          instr_valid,
        input  wire instruction_t  instruction,
        output wb_t                wb
);

        decoded_t decoded;

        decode_stage u_decode_stage (
                .clk         (clk),
                .rst_n       (rst_n),
                .instr_valid (instr_valid),
                .instruction (instruction),
                .decoded     (decoded)
        );

        execute_stage u_execute_stage (
                .clk     (clk),
                .rst_n   (rst_n),
                .decoded (decoded),
                .wb      (wb)
        );

endmodule

`default_nettype wire

//--- verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

        localparam int xlen        = 32;
        localparam int reg_addr_w  = 5;
        localparam int dmem_words  = 64;
        localparam int dmem_addr_w = 6;

        localparam logic [6:0] op_lui    = 7'b0110111;
        localparam logic [6:0] op_branch = 7'b1100011;
        localparam logic [6:0] op_load   = 7'b0000011;
        localparam logic [6:0] op_store  = 7'b0100011;
        localparam logic [6:0] op_imm    = 7'b0010011;
        localparam logic [6:0] op_reg    = 7'b0110011;

        typedef struct packed {
                logic [6:0]            funct7;
                logic [reg_addr_w-1:0] rs2;
                logic [reg_addr_w-1:0] rs1;
                logic [2:0]            funct3;
                logic [reg_addr_w-1:0] rd;
                logic [6:0]            opcode;
        } r_fmt_t;

        typedef struct packed {
                logic [11:0]           imm_11_0;
                logic [reg_addr_w-1:0] rs1;
                logic [2:0]            funct3;
                logic [reg_addr_w-1:0] rd;
                logic [6:0]            opcode;
        } i_fmt_t;

        typedef struct packed {
                logic [6:0]            imm_11_5;
                logic [reg_addr_w-1:0] rs2;
                logic [reg_addr_w-1:0] rs1;
                logic [2:0]            funct3;
                logic [4:0]            imm_4_0;
                logic [6:0]            opcode;
        } s_fmt_t;

        typedef struct packed {
                logic                  imm_12;
                logic [5:0]            imm_10_5;
                logic [reg_addr_w-1:0] rs2;
                logic [reg_addr_w-1:0] rs1;
                logic [2:0]            funct3;
                logic [3:0]            imm_4_1;
                logic                  imm_11;
                logic [6:0]            opcode;
        } b_fmt_t;

        typedef struct packed {
                logic [19:0]           imm_31_12;
                logic [reg_addr_w-1:0] rd;
                logic [6:0]            opcode;
        } u_fmt_t;

        // five views of one instruction word
        typedef union packed {
                r_fmt_t r_fmt;
                i_fmt_t i_fmt;
                s_fmt_t s_fmt;
                b_fmt_t b_fmt;
                u_fmt_t u_fmt;
        } instruction_t;

        typedef enum logic [2:0] {
                R_TYPE,
                I_TYPE,
                S_TYPE,
                B_TYPE,
                U_TYPE,
                J_TYPE
        } encoding_t;

        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SHIFT_LEFT,
                ALU_SHIFT_RIGHT,
                ALU_SHIFT_RIGHT_AR,
                ALU_LESS_THAN_SIGNED,
                ALU_LESS_THAN_UNSIGNED,
                ALU_PASS_B
        } alu_op_t;

        typedef struct packed {
                alu_op_t               alu_op;
                encoding_t             encoding;
                logic                  alu_src;    // imm as operand b
                logic                  mem_read;
                logic                  mem_write;
                logic                  is_branch;
                logic                  reg_write;
                logic [reg_addr_w-1:0] write_back_id;
        } control_t;

        typedef struct packed {
                logic                  valid;
                control_t              ctrl;
                logic [reg_addr_w-1:0] rs1;
                logic [reg_addr_w-1:0] rs2;
                logic [2:0]            funct3;
                logic [xlen-1:0]       imm;
        } decoded_t;

        typedef struct packed {
                logic                  valid;
                logic                  reg_write;
                logic                  mem_write;
                logic                  branch_taken;
                logic [reg_addr_w-1:0] rd;
                logic [xlen-1:0]       data;
        } wb_t;

endpackage

`default_nettype wire
